// File: mesh_router.f
hw/noc_pkg.sv
hw/input_queue.sv
hw/input_port.sv
hw/port_arbiter.sv
hw/output_port.sv
hw/mesh_router.sv
test/tb_mesh_router.sv

// File: test/tb_mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mesh_router;

    localparam int unsigned max_len    = 8;
    localparam int unsigned wait_limit = 100;

    logic                 clk;
    logic                 rst;
    noc_pkg::xy_t         position_i;
    noc_pkg::link_array_t link_i;
    noc_pkg::port_mask_t  stop_o;
    noc_pkg::link_array_t link_o;
    noc_pkg::port_mask_t  stop_i;

    // One worm waiting to be sent per input port
    noc_pkg::flit_t worm_mem [noc_pkg::num_ports][max_len];
    int unsigned    worm_len [noc_pkg::num_ports];

    noc_pkg::flit_t expect_q[$];
    logic [31:0]    lfsr_state = 32'hf41f;
    int unsigned    cycle_count = 0;
    int unsigned    write_cycle;
    int unsigned    last_arrival;
    // Round-robin pointer of the Local output
    int unsigned    local_ptr;

    mesh_router uut (
        .clk        (clk),
        .rst        (rst),
        .position_i (position_i),
        .link_i     (link_i),
        .stop_o     (stop_o),
        .link_o     (link_o),
        .stop_i     (stop_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flit(input string name, input noc_pkg::flit_t got,
                              input noc_pkg::flit_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_dir(input string name, input noc_pkg::direction_t got,
                             input noc_pkg::direction_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Direction the next router must take as seen from here
    function automatic noc_pkg::direction_t next_hop(input noc_pkg::direction_t route,
                                                     input noc_pkg::coord_t dest_x);
        int here;
        int ahead;
        here  = position_i.x;
        ahead = here;
        if (route == noc_pkg::go_east) begin
            ahead = here + 1;
        end else if (route == noc_pkg::go_west) begin
            ahead = here - 1;
        end
        if (int'(dest_x) > ahead) begin
            return noc_pkg::go_east;
        end else if (int'(dest_x) < ahead) begin
            return noc_pkg::go_west;
        end
        return noc_pkg::go_local;
    endfunction

    function automatic int unsigned rr_winner(input int unsigned ptr,
                                              input noc_pkg::port_mask_t req);
        int unsigned idx;
        for (int unsigned i = 0; i < noc_pkg::num_ports; i++) begin
            idx = (ptr + i) % noc_pkg::num_ports;
            if (req[idx]) begin
                return idx;
            end
        end
        return ptr;
    endfunction

    task automatic build_worm(input int unsigned src, input noc_pkg::coord_t dst_x,
                              input noc_pkg::direction_t route, input int unsigned len);
        noc_pkg::flit_t f;
        worm_len[src] = len;
        for (int unsigned k = 0; k < len; k++) begin
            f = '0;
            if (k == 0) begin
                f.header.preamble.head  = 1'b1;
                f.header.source.x       = noc_pkg::coord_t'(random_bits(4));
                f.header.destination.x  = dst_x;
                f.header.message        = noc_pkg::message_t'(random_bits(5));
                f.header.reserved       = 8'(random_bits(8));
                f.header.routing        = route;
            end else begin
                f.body.data = random_bits(32);
            end
            f.header.preamble.tail = (k == len - 1);
            worm_mem[src][k] = f;
        end
    endtask

    // Heads get the look-ahead field while bodies stay as sent
    task automatic expect_worm(input int unsigned src);
        noc_pkg::flit_t f;
        for (int unsigned k = 0; k < worm_len[src]; k++) begin
            f = worm_mem[src][k];
            if (f.header.preamble.head) begin
                f.header.routing = next_hop(f.header.routing, f.header.destination.x);
            end
            expect_q.push_back(f);
        end
    endtask

    task automatic send_worm(input int unsigned src);
        int unsigned waited;
        for (int unsigned k = 0; k < worm_len[src]; k++) begin
            @(negedge clk);
            link_i[src].is_void = 1'b0;
            link_i[src].flit    = worm_mem[src][k];
            waited = 0;
            @(posedge clk);
            while (stop_o[src]) begin
                waited++;
                if (waited > wait_limit) begin
                    fail_run($sformatf("input %0d stayed stopped for %0d cycles", src, waited));
                end
                @(posedge clk);
            end
            if (k == 0) begin
                write_cycle = cycle_count;
            end
        end
        @(negedge clk);
        link_i[src].is_void = 1'b1;
    endtask

    task automatic receive_flits(input int unsigned out, input int unsigned n);
        noc_pkg::flit_t exp;
        int unsigned    waited;
        for (int unsigned k = 0; k < n; k++) begin
            waited = 0;
            @(posedge clk);
            // A flit counts only on an edge where it is consumed
            while (link_o[out].is_void || stop_i[out]) begin
                waited++;
                if (waited > wait_limit) begin
                    fail_run($sformatf("no flit arrived on output %0d within %0d cycles",
                                       out, wait_limit));
                end
                @(posedge clk);
            end
            last_arrival = cycle_count;
            if (expect_q.size() == 0) begin
                fail_run($sformatf("unexpected flit on output %0d", out));
            end
            exp = expect_q.pop_front();
            if (exp.header.preamble.head) begin
                check_dir($sformatf("link_o[%0d] routing", out),
                          link_o[out].flit.header.routing, exp.header.routing);
            end
            check_flit($sformatf("link_o[%0d] flit", out), link_o[out].flit, exp);
        end
    endtask

    task automatic check_idle(input int unsigned cycles);
        repeat (cycles) begin
            @(posedge clk);
            for (int unsigned p = 0; p < noc_pkg::num_ports; p++) begin
                check_bit($sformatf("link_o[%0d] void", p), link_o[p].is_void, 1'b1);
            end
        end
        if (expect_q.size() != 0) begin
            fail_run($sformatf("%0d expected flits never arrived", expect_q.size()));
        end
    endtask

    task automatic check_held(input noc_pkg::link_t held);
        check_bit("link_o[0] void under stop", link_o[noc_pkg::port_east].is_void, held.is_void);
        check_flit("link_o[0] flit under stop", link_o[noc_pkg::port_east].flit, held.flit);
    endtask

    // Stalls East after its first flit and releases it once Local is full
    task automatic watch_stall();
        noc_pkg::link_t held;
        int unsigned    waited;
        waited = 0;
        @(posedge clk);
        while (link_o[noc_pkg::port_east].is_void) begin
            waited++;
            if (waited > wait_limit) begin
                fail_run("no flit reached the East output before the stall");
            end
            @(posedge clk);
        end
        @(negedge clk);
        stop_i[noc_pkg::port_east] = 1'b1;
        @(posedge clk);
        held = link_o[noc_pkg::port_east];
        check_bit("link_o[0] void at stall", held.is_void, 1'b0);
        waited = 0;
        while (!stop_o[noc_pkg::port_local]) begin
            check_held(held);
            waited++;
            if (waited > wait_limit) begin
                fail_run("stop_o of the Local input never rose while East was stalled");
            end
            @(posedge clk);
        end
        repeat (4) begin
            @(posedge clk);
            check_held(held);
            check_bit("stop_o[2]", stop_o[noc_pkg::port_local], 1'b1);
        end
        @(negedge clk);
        stop_i[noc_pkg::port_east] = 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_state();
        @(posedge clk);
        for (int unsigned p = 0; p < noc_pkg::num_ports; p++) begin
            check_bit($sformatf("link_o[%0d] void", p), link_o[p].is_void, 1'b1);
            check_bit($sformatf("stop_o[%0d]", p), stop_o[p], 1'b0);
        end
    endtask

    task automatic single_flit_latency();
        build_worm(noc_pkg::port_local, 4'd9, noc_pkg::go_east, 1);
        expect_worm(noc_pkg::port_local);
        fork
            send_worm(noc_pkg::port_local);
            receive_flits(noc_pkg::port_east, 1);
        join
        if (last_arrival - write_cycle != 2) begin
            fail_run($sformatf("mismatch at %0t: latency got %0d expected 2",
                               $time, last_arrival - write_cycle));
        end
        check_idle(3);
    endtask

    task automatic worm_routes();
        build_worm(noc_pkg::port_west, 4'd5, noc_pkg::go_local, 5);
        expect_worm(noc_pkg::port_west);
        local_ptr = (rr_winner(local_ptr, 3'b010) + 1) % noc_pkg::num_ports;
        fork
            send_worm(noc_pkg::port_west);
            receive_flits(noc_pkg::port_local, 5);
        join
        check_idle(3);
        build_worm(noc_pkg::port_east, 4'd2, noc_pkg::go_west, 4);
        expect_worm(noc_pkg::port_east);
        fork
            send_worm(noc_pkg::port_east);
            receive_flits(noc_pkg::port_west, 4);
        join
        check_idle(3);
    endtask

    task automatic contention_order();
        int unsigned first;
        int unsigned second;
        for (int unsigned round = 0; round < 2; round++) begin
            if (round != 0) begin
                // A lone East worm leaves West next in line
                build_worm(noc_pkg::port_east, 4'd5, noc_pkg::go_local, 1);
                expect_worm(noc_pkg::port_east);
                local_ptr = (rr_winner(local_ptr, 3'b001) + 1) % noc_pkg::num_ports;
                fork
                    send_worm(noc_pkg::port_east);
                    receive_flits(noc_pkg::port_local, 1);
                join
                check_idle(3);
            end
            build_worm(noc_pkg::port_east, 4'd5, noc_pkg::go_local, 6);
            build_worm(noc_pkg::port_west, 4'd5, noc_pkg::go_local, 5);
            first     = rr_winner(local_ptr, 3'b011);
            local_ptr = (first + 1) % noc_pkg::num_ports;
            second    = rr_winner(local_ptr, (first == noc_pkg::port_east) ? 3'b010 : 3'b001);
            local_ptr = (second + 1) % noc_pkg::num_ports;
            // Whole worms in arbitration order without interleaving
            expect_worm(first);
            expect_worm(second);
            fork
                send_worm(noc_pkg::port_east);
                send_worm(noc_pkg::port_west);
                receive_flits(noc_pkg::port_local, 11);
            join
            check_idle(3);
        end
    endtask

    task automatic back_pressure();
        build_worm(noc_pkg::port_local, 4'd9, noc_pkg::go_east, max_len);
        expect_worm(noc_pkg::port_local);
        fork
            send_worm(noc_pkg::port_local);
            receive_flits(noc_pkg::port_east, max_len);
            watch_stall();
        join
        check_idle(4);
    endtask

    initial begin
        rst          = 1'b1;
        position_i.x = 4'd5;
        position_i.y = 4'd0;
        stop_i       = '0;
        local_ptr    = noc_pkg::port_east;
        for (int unsigned p = 0; p < noc_pkg::num_ports; p++) begin
            link_i[p].is_void = 1'b1;
            link_i[p].flit    = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        single_flit_latency();
        worm_routes();
        contention_order();
        back_pressure();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire noc_pkg::xy_t         position_i,
    input  wire noc_pkg::link_array_t link_i,
    output noc_pkg::port_mask_t       stop_o,
    output noc_pkg::link_array_t      link_o,
    input  wire noc_pkg::port_mask_t  stop_i
);

    noc_pkg::cand_array_t cand;

    // rd_by_out[o][i] is output o popping input i
    noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] rd_by_out;
    noc_pkg::port_mask_t [noc_pkg::num_ports-1:0] rd_by_in;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : gen_input
        input_port u_input (
            .clk        (clk),
            .rst        (rst),
            .position_i (position_i),
            .link_i     (link_i[i]),
            .rd_i       (rd_by_in[i]),
            .stop_o     (stop_o[i]),
            .cand_o     (cand[i])
        );
    end

    // Turn per-output read vectors into per-input ones
    for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : gen_rd_out
        for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : gen_rd_in
            assign rd_by_in[i][o] = rd_by_out[o][i];
        end
    end

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    for (genvar o = 0; o < noc_pkg::num_ports; o++) begin : gen_output
        output_port #(
            .out_port (o)
        ) u_output (
            .clk    (clk),
            .rst    (rst),
            .cand_i (cand),
            .stop_i (stop_i[o]),
            .link_o (link_o[o]),
            .rd_o   (rd_by_out[o])
        );
    end

endmodule

`default_nettype wire

// File: hw/output_port.sv
`timescale 1ns/1ps
`default_nettype none

module output_port #(
    parameter int unsigned out_port = noc_pkg::port_east
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire noc_pkg::cand_array_t cand_i,
    input  wire logic                 stop_i,
    output noc_pkg::link_t            link_o,
    output noc_pkg::port_mask_t       rd_o
);

    noc_pkg::worm_state_t state_q;
    noc_pkg::worm_state_t state_d;
    noc_pkg::port_mask_t  req;
    noc_pkg::port_mask_t  arb_req;
    noc_pkg::port_mask_t  grant;
    noc_pkg::port_mask_t  locked_q;
    noc_pkg::flit_t       sel_flit;
    noc_pkg::flit_t       flit_q;
    logic                 void_q;
    logic                 fwd;
    logic                 fwd_tail;

    ////////////////////////////////////////
    // Requests and arbitration
    ////////////////////////////////////////

    always_comb begin
        for (int unsigned j = 0; j < noc_pkg::num_ports; j++) begin
            req[j] = cand_i[j].valid & cand_i[j].req[out_port];
        end
    end

    // Mid-worm only the locked input may compete
    assign arb_req = (state_q == noc_pkg::forward_body) ? (req & locked_q) : req;

    port_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .req_i     (arb_req),
        .advance_i (fwd_tail),
        .grant_o   (grant)
    );

    ////////////////////////////////////////
    // Crossbar selection
    ////////////////////////////////////////

    always_comb begin
        sel_flit = '0;
        for (int unsigned j = 0; j < noc_pkg::num_ports; j++) begin
            if (grant[j]) begin
                sel_flit = cand_i[j].flit;
            end
        end
    end

    assign fwd      = (|grant) & ~stop_i;
    assign fwd_tail = fwd & sel_flit.header.preamble.tail;
    assign rd_o     = fwd ? grant : '0;

    ////////////////////////////////////////
    // Worm state machine
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            noc_pkg::wait_head: begin
                // A single-flit worm never leaves wait_head
                if (fwd && !sel_flit.header.preamble.tail) begin
                    state_d = noc_pkg::forward_body;
                end
            end
            noc_pkg::forward_body: begin
                if (fwd_tail) begin
                    state_d = noc_pkg::wait_head;
                end
            end
            default: begin
                state_d = noc_pkg::wait_head;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= noc_pkg::wait_head;
            locked_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == noc_pkg::wait_head && fwd) begin
                locked_q <= grant;
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    // Stop freezes the link, otherwise void follows fwd
    always_ff @(posedge clk) begin
        if (rst) begin
            void_q <= 1'b1;
        end else if (!stop_i) begin
            void_q <= ~fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            flit_q <= sel_flit;
        end
    end

    assign link_o.is_void = void_q;
    assign link_o.flit    = flit_q;

endmodule

`default_nettype wire

// File: hw/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire noc_pkg::port_mask_t req_i,
    input  wire logic                advance_i,
    output noc_pkg::port_mask_t      grant_o
);

    noc_pkg::port_idx_t ptr_q;
    noc_pkg::port_idx_t winner;

    // First requester at or after the pointer wins
    always_comb begin
        int unsigned idx;
        logic        found;
        grant_o = '0;
        winner  = ptr_q;
        found   = 1'b0;
        for (int unsigned i = 0; i < noc_pkg::num_ports; i++) begin
            idx = ptr_q + i;
            if (idx >= noc_pkg::num_ports) begin
                idx = idx - noc_pkg::num_ports;
            end
            if (!found && req_i[idx]) begin
                found        = 1'b1;
                grant_o[idx] = 1'b1;
                winner       = noc_pkg::port_idx_t'(idx);
            end
        end
    end

    // Winner drops to lowest priority once its tail is out
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= noc_pkg::port_idx_t'(noc_pkg::port_east);
        end else if (advance_i) begin
            ptr_q <= (winner == noc_pkg::port_idx_t'(noc_pkg::num_ports - 1)) ? '0
                                                                             : winner + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire noc_pkg::xy_t        position_i,
    input  wire noc_pkg::link_t      link_i,
    input  wire noc_pkg::port_mask_t rd_i,
    output logic                     stop_o,
    output noc_pkg::cand_t           cand_o
);

    noc_pkg::flit_t      head;
    noc_pkg::direction_t saved_req;
    noc_pkg::direction_t req;
    noc_pkg::direction_t next_route;
    noc_pkg::coord_t     next_x;
    logic                empty;
    logic                full;
    logic                pop;
    logic                is_head;

    assign pop = |rd_i;

    input_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .wr_i    (~link_i.is_void),
        .data_i  (link_i.flit),
        .rd_i    (pop),
        .head_o  (head),
        .empty_o (empty),
        .full_o  (full)
    );

    assign stop_o  = full;
    assign is_head = ~empty & head.header.preamble.head;

    ////////////////////////////////////////
    // Route request of the current worm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            saved_req <= '0;
        end else if (pop && !empty) begin
            if (head.header.preamble.tail) begin
                saved_req <= '0;
            end else if (head.header.preamble.head) begin
                saved_req <= head.header.routing;
            end
        end
    end

    // Body flits reuse the request their head carried
    assign req = is_head ? head.header.routing : saved_req;

    ////////////////////////////////////////
    // Look-ahead for the next hop
    ////////////////////////////////////////

    always_comb begin
        // X of the router behind the chosen output
        if (head.header.routing[noc_pkg::port_east]) begin
            next_x = position_i.x + noc_pkg::coord_t'(1);
        end else if (head.header.routing[noc_pkg::port_west]) begin
            next_x = position_i.x - noc_pkg::coord_t'(1);
        end else begin
            next_x = position_i.x;
        end

        if (head.header.destination.x > next_x) begin
            next_route = noc_pkg::go_east;
        end else if (head.header.destination.x < next_x) begin
            next_route = noc_pkg::go_west;
        end else begin
            next_route = noc_pkg::go_local;
        end
    end

    always_comb begin
        cand_o.valid = ~empty;
        cand_o.req   = req;
        cand_o.flit  = head;
        if (is_head) begin
            cand_o.flit.header.routing = next_route;
        end
    end

endmodule

`default_nettype wire

// File: hw/input_queue.sv
`timescale 1ns/1ps
`default_nettype none

module input_queue (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           wr_i,
    input  wire noc_pkg::flit_t data_i,
    input  wire logic           rd_i,
    output noc_pkg::flit_t      head_o,
    output logic                empty_o,
    output logic                full_o
);

    noc_pkg::flit_t   mem [noc_pkg::queue_depth];
    noc_pkg::qptr_t   wr_ptr;
    noc_pkg::qptr_t   rd_ptr;
    noc_pkg::qcount_t count;
    logic             empty_q;
    logic             full_q;
    logic             do_wr;
    logic             do_rd;

    // A read on an empty queue is dropped
    assign do_wr = wr_i & ~full_q;
    assign do_rd = rd_i & ~empty_q;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            empty_q <= 1'b1;
            full_q  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == noc_pkg::qptr_t'(noc_pkg::queue_depth - 1)) ? '0
                                                                               : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == noc_pkg::qptr_t'(noc_pkg::queue_depth - 1)) ? '0
                                                                               : rd_ptr + 1'b1;
            end
            // Flags only move when the count changes
            case ({do_wr, do_rd})
                2'b10: begin
                    count   <= count + 1'b1;
                    empty_q <= 1'b0;
                    full_q  <= (count == noc_pkg::qcount_t'(noc_pkg::queue_depth - 1));
                end
                2'b01: begin
                    count   <= count - 1'b1;
                    full_q  <= 1'b0;
                    empty_q <= (count == noc_pkg::qcount_t'(1));
                end
                default: begin
                end
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];
    assign empty_o = empty_q;
    assign full_o  = full_q;

endmodule

`default_nettype wire

// File: hw/noc_pkg.sv
`default_nettype none

package noc_pkg;

    ////////////////////////////////////////
    // Sizes and port indices
    ////////////////////////////////////////

    localparam int unsigned coord_w     = 4;
    localparam int unsigned data_w      = 32;
    localparam int unsigned queue_depth = 4;
    localparam int unsigned num_ports   = 3;

    localparam int unsigned port_east  = 0;
    localparam int unsigned port_west  = 1;
    localparam int unsigned port_local = 2;

    ////////////////////////////////////////
    // Flit and header types
    ////////////////////////////////////////

    typedef logic [coord_w-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } xy_t;

    typedef logic [4:0] message_t;

    // One-hot, bit n requests output port n
    typedef logic [num_ports-1:0] direction_t;

    localparam direction_t go_east  = direction_t'(1 << port_east);
    localparam direction_t go_west  = direction_t'(1 << port_west);
    localparam direction_t go_local = direction_t'(1 << port_local);

    typedef struct packed {
        logic head;
        logic tail;
    } preamble_t;

    typedef struct packed {
        preamble_t  preamble;
        xy_t        source;
        xy_t        destination;
        message_t   message;
        logic [7:0] reserved;
        direction_t routing;
    } header_t;

    typedef struct packed {
        preamble_t         preamble;
        logic [data_w-1:0] data;
    } body_t;

    typedef union packed {
        header_t header;
        body_t   body;
    } flit_t;

    ////////////////////////////////////////
    // Link and crossbar types
    ////////////////////////////////////////

    // Void high means no flit on the link
    typedef struct packed {
        logic  is_void;
        flit_t flit;
    } link_t;

    typedef struct packed {
        logic       valid;
        direction_t req;
        flit_t      flit;
    } cand_t;

    typedef link_t [num_ports-1:0] link_array_t;
    typedef cand_t [num_ports-1:0] cand_array_t;
    typedef logic  [num_ports-1:0] port_mask_t;

    typedef logic [$clog2(num_ports)-1:0]     port_idx_t;
    typedef logic [$clog2(queue_depth)-1:0]   qptr_t;
    typedef logic [$clog2(queue_depth+1)-1:0] qcount_t;

    typedef enum logic {
        wait_head    = 1'b0,
        forward_body = 1'b1
    } worm_state_t;

endpackage

`default_nettype wire
